// ==== riscv_core.f ====
hdl/riscv_isa_pkg.sv
hdl/core_ctrl_pkg.sv
hdl/control_unit.sv
hdl/operand_fetch.sv
hdl/execute_stage.sv
hdl/riscv_core.sv
dv/riscv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= riscv_core_tb
FLIST     ?= riscv_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST)) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# Exit status comes from the search for the pass line
run: compile
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/riscv_core_tb.sv ====
`default_nettype none

module riscv_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_ROWS = 64;

    logic                  clk;
    logic                  rst_n;
    riscv_isa_pkg::addr_t  instr_addr;
    riscv_isa_pkg::instr_t instr_rdata;
    riscv_isa_pkg::addr_t  dmem_addr;
    riscv_isa_pkg::word_t  dmem_wdata;
    logic                  dmem_we;
    logic                  dmem_re;
    riscv_isa_pkg::word_t  dmem_rdata;

    ////////////////////////////////////////
    // Program table and data memory
    ////////////////////////////////////////
    riscv_isa_pkg::instr_t prog_instr [MAX_ROWS];
    riscv_isa_pkg::addr_t  prog_next  [MAX_ROWS];  // Expected pc after the row
    logic                  prog_re    [MAX_ROWS];
    logic                  prog_we    [MAX_ROWS];
    riscv_isa_pkg::addr_t  prog_maddr [MAX_ROWS];  // lw/sw address
    riscv_isa_pkg::word_t  prog_wdata [MAX_ROWS];  // sw data
    int                    prog_test  [MAX_ROWS];  // Behavior the row belongs to
    int                    n_prog = 0;
    riscv_isa_pkg::word_t  dmem [256];             // 1 KiB from address 0

    string test_names [1:5] = '{"reset", "arithmetic", "loads", "branches", "edge rules"};

    logic [31:0] lcg_state = 32'hc973;
    int checks = 0;
    int errors = 0;
    int err_mark = 0;   // errors when the running test began
    int tests_run = 0;
    int tests_failed = 0;
    int cycles = 0;

    riscv_core dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    function automatic riscv_isa_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [11:0] rand_imm();
        riscv_isa_pkg::word_t r;
        r = lcg_next();
        return r[11:0];
    endfunction

    function automatic riscv_isa_pkg::word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Anything past 1 KiB reads a pattern of its whole address
    function automatic riscv_isa_pkg::word_t dmem_read(input riscv_isa_pkg::addr_t a);
        if (a[31:10] != '0)
            return a ^ 32'h5a5a_a5a5;
        else
            return dmem[a[9:2]];
    endfunction

    // Instruction encoders, straight from the RV32I formats
    function automatic riscv_isa_pkg::instr_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
        input riscv_isa_pkg::opcode_t op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic riscv_isa_pkg::instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input riscv_isa_pkg::opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic riscv_isa_pkg::instr_t enc_s(input logic [11:0] o, input logic [4:0] rs2);
        return {o[11:5], rs2, 5'd0, 3'b010, o[4:0], riscv_isa_pkg::OP_STORE};  // sw, base x0
    endfunction

    function automatic riscv_isa_pkg::instr_t enc_b(input logic [12:0] o, input logic [4:0] rs1,
        input logic [4:0] rs2, input logic [2:0] f3);
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], riscv_isa_pkg::OP_BRANCH};
    endfunction

    task automatic append_row(input int test, input riscv_isa_pkg::instr_t instr, input logic re,
                              input logic we, input int maddr, input riscv_isa_pkg::word_t wdata);
        prog_instr[n_prog] = instr;
        prog_next[n_prog]  = riscv_isa_pkg::addr_t'(4 * n_prog + 4);  // Fall through
        prog_re[n_prog]    = re;
        prog_we[n_prog]    = we;
        prog_maddr[n_prog] = riscv_isa_pkg::addr_t'(maddr);
        prog_wdata[n_prog] = wdata;
        prog_test[n_prog]  = test;
        n_prog++;
    endtask

    task automatic alu_row(input int test, input riscv_isa_pkg::instr_t instr);
        append_row(test, instr, 1'b0, 1'b0, 0, '0);
    endtask

    task automatic store_row(input int test, input int src, input int off,
                             input riscv_isa_pkg::word_t data);
        append_row(test, enc_s(off[11:0], src[4:0]), 1'b0, 1'b1, off, data);
    endtask

    task automatic branch_row(input int test, input logic [2:0] f3, input int rs1, input int rs2,
                              input int off, input logic taken);
        append_row(test, enc_b(off[12:0], rs1[4:0], rs2[4:0], f3), 1'b0, 1'b0, 0, '0);
        if (taken) begin
            prog_next[n_prog-1] = riscv_isa_pkg::addr_t'(4 * (n_prog - 1) + off);
        end
    endtask

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic check_addr(input string what, input riscv_isa_pkg::addr_t got,
                              input riscv_isa_pkg::addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input riscv_isa_pkg::word_t got,
                              input riscv_isa_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input int t);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", t, test_names[t]);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", t, test_names[t], errors - err_mark);
        end
        err_mark = errors;
    endtask

    ////////////////////////////////////////
    // Program and expected values
    ////////////////////////////////////////
    task automatic build_program();
        logic [11:0]          ia;
        logic [11:0]          ib;
        logic [11:0]          ic;
        logic [11:0]          id;
        logic [11:0]          ie;
        riscv_isa_pkg::word_t x [1:10];  // Expected x1..x10
        riscv_isa_pkg::word_t w0;
        riscv_isa_pkg::word_t w1;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = riscv_isa_pkg::addr_t'(4 * i) ^ 32'h5a5a_a5a5;
        end
        ia = rand_imm();
        ib = rand_imm() | 12'h800;  // Negative immediate
        ic = rand_imm();
        id = rand_imm();
        ie = rand_imm();
        x[1]  = sext12(ia);
        x[2]  = sext12(ib);
        x[3]  = x[1] & sext12(ic);
        x[4]  = x[2] | sext12(id);
        x[5]  = ($signed(x[2]) < $signed(sext12(ie))) ? 32'd1 : 32'd0;
        x[6]  = x[1] + x[2];
        x[7]  = x[1] - x[2];
        x[8]  = x[1] & x[2];
        x[9]  = x[1] | x[2];
        x[10] = ($signed(x[1]) < $signed(x[2])) ? 32'd1 : 32'd0;
        alu_row(2, enc_i(ia, 5'd0, riscv_isa_pkg::F3_ADD_SUB, 5'd1, riscv_isa_pkg::OP_I_TYPE));
        alu_row(2, enc_i(ib, 5'd0, riscv_isa_pkg::F3_ADD_SUB, 5'd2, riscv_isa_pkg::OP_I_TYPE));
        alu_row(2, enc_i(ic, 5'd1, riscv_isa_pkg::F3_AND, 5'd3, riscv_isa_pkg::OP_I_TYPE));
        alu_row(2, enc_i(id, 5'd2, riscv_isa_pkg::F3_OR, 5'd4, riscv_isa_pkg::OP_I_TYPE));
        alu_row(2, enc_i(ie, 5'd2, riscv_isa_pkg::F3_SLT, 5'd5, riscv_isa_pkg::OP_I_TYPE));
        alu_row(2, enc_r(7'h00, 5'd2, 5'd1, riscv_isa_pkg::F3_ADD_SUB, 5'd6, 7'b0110011));
        alu_row(2, enc_r(7'h20, 5'd2, 5'd1, riscv_isa_pkg::F3_ADD_SUB, 5'd7, 7'b0110011));  // sub
        alu_row(2, enc_r(7'h00, 5'd2, 5'd1, riscv_isa_pkg::F3_AND, 5'd8, 7'b0110011));
        alu_row(2, enc_r(7'h00, 5'd2, 5'd1, riscv_isa_pkg::F3_OR, 5'd9, 7'b0110011));
        alu_row(2, enc_r(7'h00, 5'd2, 5'd1, riscv_isa_pkg::F3_SLT, 5'd10, 7'b0110011));
        for (int k = 1; k <= 10; k++) begin
            store_row(2, k, 32'h1fc + 4 * k, x[k]);  // x1..x10 to 0x200..0x224
        end

        // Loads of LCG words, then sum and difference
        w0 = lcg_next();
        w1 = lcg_next();
        dmem[32'h100 >> 2] = w0;
        dmem[32'h104 >> 2] = w1;
        append_row(3, enc_i(12'h100, 5'd0, 3'b010, 5'd11, riscv_isa_pkg::OP_LOAD), 1'b1, 1'b0,
                   32'h100, '0);
        append_row(3, enc_i(12'h104, 5'd0, 3'b010, 5'd12, riscv_isa_pkg::OP_LOAD), 1'b1, 1'b0,
                   32'h104, '0);
        alu_row(3, enc_r(7'h00, 5'd12, 5'd11, riscv_isa_pkg::F3_ADD_SUB, 5'd13, 7'b0110011));
        alu_row(3, enc_r(7'h20, 5'd12, 5'd11, riscv_isa_pkg::F3_ADD_SUB, 5'd14, 7'b0110011));
        store_row(3, 13, 32'h240, w0 + w1);
        store_row(3, 14, 32'h244, w0 - w1);

        // Visit order b, b+1, b+4, b+2, b+3, b+6
        branch_row(4, riscv_isa_pkg::F3_BEQ, 11, 12, 8, w0 == w1);    // Not taken
        branch_row(4, riscv_isa_pkg::F3_BNE, 11, 12, 12, w0 != w1);   // Taken forward
        branch_row(4, riscv_isa_pkg::F3_BNE, 13, 13, -4, 1'b0);       // Not taken, back offset
        branch_row(4, riscv_isa_pkg::F3_BEQ, 0, 0, 12, 1'b1);
        branch_row(4, riscv_isa_pkg::F3_BEQ, 0, 0, -8, 1'b1);         // Taken backward
        store_row(4, 0, 32'h2fc, '0);                                 // Skipped slot

        // x0 write dropped, unknown opcode leaves x13 alone
        alu_row(5, enc_i(12'h055, 5'd0, riscv_isa_pkg::F3_ADD_SUB, 5'd0, riscv_isa_pkg::OP_I_TYPE));
        store_row(5, 0, 32'h250, '0);
        alu_row(5, enc_r(7'h00, 5'd1, 5'd1, riscv_isa_pkg::F3_ADD_SUB, 5'd13, 7'b0001011));
        store_row(5, 13, 32'h254, w0 + w1);
    endtask

    // Run limit from the table length
    initial begin
        wait (n_prog > 0);
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= n_prog * 4 + 20) begin
                $display("Timeout: program did not reach its end within %0d cycles", cycles);
                $display("=== FAIL ===");
                $finish;
            end
        end
    end

    ////////////////////////////////////////
    // Reset and program run
    ////////////////////////////////////////
    initial begin
        riscv_isa_pkg::addr_t exp_pc;
        riscv_isa_pkg::addr_t st_addr;
        riscv_isa_pkg::word_t st_data;
        logic                 st_en;
        logic                 done;
        int                   idx;
        int                   cur_test;
        rst_n       = 1'b0;
        instr_rdata = '0;  // Opcode 0 is unknown, strobes low
        dmem_rdata  = '0;
        build_program();

        @(posedge clk);  // pc defined from here on
        repeat (4) begin
            @(negedge clk);
            #0.5;
            check_addr("pc in reset", instr_addr, riscv_isa_pkg::RESET_PC);
            check_flag("dmem_we in reset", dmem_we, 1'b0);
            check_flag("dmem_re in reset", dmem_re, 1'b0);
            @(posedge clk);
        end
        @(negedge clk);
        rst_n = 1'b1;
        check_addr("pc after reset", instr_addr, riscv_isa_pkg::RESET_PC);
        check_flag("dmem_we after reset", dmem_we, 1'b0);
        check_flag("dmem_re after reset", dmem_re, 1'b0);
        finish_test(1);

        exp_pc   = riscv_isa_pkg::RESET_PC;
        cur_test = 0;
        done     = 1'b0;
        while (!done) begin
            check_addr("fetch address", instr_addr, exp_pc);
            idx = int'(instr_addr[31:2]);
            if (instr_addr !== exp_pc || idx >= n_prog) begin
                done = 1'b1;  // End of program, or off track
            end else begin
                if (prog_test[idx] != cur_test) begin
                    if (cur_test != 0) finish_test(cur_test);
                    cur_test = prog_test[idx];
                end
                instr_rdata = prog_instr[idx];
                #0.5;
                dmem_rdata = dmem_read(dmem_addr);  // Read port follows the address
                #0.5;
                check_flag($sformatf("row %0d dmem_re", idx), dmem_re, prog_re[idx]);
                check_flag($sformatf("row %0d dmem_we", idx), dmem_we, prog_we[idx]);
                if (prog_re[idx] || prog_we[idx])
                    check_addr($sformatf("row %0d dmem_addr", idx), dmem_addr, prog_maddr[idx]);
                if (prog_we[idx])
                    check_word($sformatf("row %0d dmem_wdata", idx), dmem_wdata, prog_wdata[idx]);
                st_en   = dmem_we;
                st_addr = dmem_addr;
                st_data = dmem_wdata;
                @(posedge clk);
                if (st_en && st_addr[31:10] == '0) dmem[st_addr[9:2]] = st_data;  // Store lands
                exp_pc = prog_next[idx];
                @(negedge clk);
            end
        end
        if (cur_test != 0) finish_test(cur_test);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/riscv_core.sv ====
`default_nettype none

module riscv_core (
    input  wire                        clk,
    input  wire                        rst_n,

    // Instruction fetch port, combinational read
    output riscv_isa_pkg::addr_t       instr_addr,   // The pc
    input  wire riscv_isa_pkg::instr_t instr_rdata,

    // Data memory port, read data same cycle
    output riscv_isa_pkg::addr_t       dmem_addr,
    output riscv_isa_pkg::word_t       dmem_wdata,
    output logic                       dmem_we,      // Written at the next edge
    output logic                       dmem_re,
    input  wire riscv_isa_pkg::word_t  dmem_rdata
);

    ////////////////////////////////////////
    // Control levels
    ////////////////////////////////////////
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
    logic                   branch;
    logic                   alu_src;
    core_ctrl_pkg::alu_op_t alu_op;

    ////////////////////////////////////////
    // Operands and writeback
    ////////////////////////////////////////
    riscv_isa_pkg::word_t rs1_data;
    riscv_isa_pkg::word_t rs2_data;
    riscv_isa_pkg::word_t imm;
    logic                 wb_en;
    riscv_isa_pkg::word_t wb_data;

    // Decode, opcode only
    control_unit u_control_unit (
        .opcode    (instr_rdata[6:0]),
        .reg_write (reg_write),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .branch    (branch),
        .alu_src   (alu_src),
        .alu_op    (alu_op)
    );

    // Register file and immediate, side by side with decode
    operand_fetch u_operand_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr_rdata),
        .wb_en    (wb_en),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm)
    );

    // ALU, branch, pc and memory drive
    execute_stage u_execute_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_write  (reg_write),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .branch     (branch),
        .alu_src    (alu_src),
        .alu_op     (alu_op),
        .funct3     (instr_rdata[14:12]),
        .funct7_b5  (instr_rdata[30]),   // sub vs add
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .dmem_rdata (dmem_rdata),
        .pc         (instr_addr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .wb_en      (wb_en),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`default_nettype none

module execute_stage (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          reg_write,
    input  wire                          mem_read,
    input  wire                          mem_write,
    input  wire                          branch,
    input  wire                          alu_src,     // 1 picks imm
    input  wire core_ctrl_pkg::alu_op_t  alu_op,
    input  wire logic [2:0]              funct3,      // instr[14:12]
    input  wire                          funct7_b5,   // instr[30], sub on R-type
    input  wire riscv_isa_pkg::word_t    rs1_data,
    input  wire riscv_isa_pkg::word_t    rs2_data,
    input  wire riscv_isa_pkg::word_t    imm,
    input  wire riscv_isa_pkg::word_t    dmem_rdata,  // Same-cycle load data
    output riscv_isa_pkg::addr_t         pc,
    output riscv_isa_pkg::addr_t         dmem_addr,
    output riscv_isa_pkg::word_t         dmem_wdata,
    output logic                         dmem_we,
    output logic                         dmem_re,
    output logic                         wb_en,
    output riscv_isa_pkg::word_t         wb_data
);

    core_ctrl_pkg::alu_sel_t alu_sel;
    riscv_isa_pkg::word_t    alu_b;
    riscv_isa_pkg::word_t    alu_result;
    logic                    alu_zero;     // rs1 == rs2 during a branch
    logic                    take_branch;
    riscv_isa_pkg::addr_t    pc_next;

    // Arithmetic funct3 group to ALU function
    function automatic core_ctrl_pkg::alu_sel_t arith_sel(input logic [2:0] f3,
                                                          input logic       sub);
        core_ctrl_pkg::alu_sel_t sel;
        case (f3)
            riscv_isa_pkg::F3_ADD_SUB: sel = sub ? core_ctrl_pkg::ALU_SUB
                                                 : core_ctrl_pkg::ALU_ADD;
            riscv_isa_pkg::F3_SLT:     sel = core_ctrl_pkg::ALU_SLT;
            riscv_isa_pkg::F3_OR:      sel = core_ctrl_pkg::ALU_OR;
            riscv_isa_pkg::F3_AND:     sel = core_ctrl_pkg::ALU_AND;
            default:                   sel = core_ctrl_pkg::ALU_ADD;
        endcase
        return sel;
    endfunction

    ////////////////////////////////////////
    // ALU control
    ////////////////////////////////////////
    always_comb begin
        case (alu_op)
            core_ctrl_pkg::ALU_OP_ADDR: begin
                // lw/sw funct3 is 010, would alias slti
                if (mem_read || mem_write) alu_sel = core_ctrl_pkg::ALU_ADD;
                else                       alu_sel = arith_sel(funct3, 1'b0);  // No subi
            end
            core_ctrl_pkg::ALU_OP_BRANCH: alu_sel = core_ctrl_pkg::ALU_SUB;
            core_ctrl_pkg::ALU_OP_REG:    alu_sel = arith_sel(funct3, funct7_b5);
            default:                      alu_sel = core_ctrl_pkg::ALU_ADD;
        endcase
    end

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////
    assign alu_b = alu_src ? imm : rs2_data;

    always_comb begin
        case (alu_sel)
            core_ctrl_pkg::ALU_ADD: alu_result = rs1_data + alu_b;
            core_ctrl_pkg::ALU_SUB: alu_result = rs1_data - alu_b;
            core_ctrl_pkg::ALU_AND: alu_result = rs1_data & alu_b;
            core_ctrl_pkg::ALU_OR:  alu_result = rs1_data | alu_b;
            core_ctrl_pkg::ALU_SLT: begin
                alu_result = {{(riscv_isa_pkg::XLEN-1){1'b0}},
                              ($signed(rs1_data) < $signed(alu_b))};
            end
            default:                alu_result = '0;
        endcase
    end

    assign alu_zero = (alu_result == '0);  // Equality from rs1 - rs2

    ////////////////////////////////////////
    // Branch and pc
    ////////////////////////////////////////
    always_comb begin
        take_branch = 1'b0;
        if (branch) begin
            case (funct3)
                riscv_isa_pkg::F3_BEQ: take_branch = alu_zero;
                riscv_isa_pkg::F3_BNE: take_branch = !alu_zero;
                default:               take_branch = 1'b0;  // blt etc. not taken
            endcase
        end
    end

    assign pc_next = take_branch ? (pc + imm) : (pc + riscv_isa_pkg::INSTR_BYTES);

    always_ff @(posedge clk) begin
        if (!rst_n) pc <= riscv_isa_pkg::RESET_PC;
        else        pc <= pc_next;
    end

    ////////////////////////////////////////
    // Data memory and writeback
    ////////////////////////////////////////
    assign dmem_addr  = alu_result;  // rs1 + imm on lw/sw
    assign dmem_wdata = rs2_data;
    assign dmem_we    = mem_write;   // Environment writes at the next edge
    assign dmem_re    = mem_read;

    assign wb_en   = reg_write;                          // x0 filtered in the regfile
    assign wb_data = mem_read ? dmem_rdata : alu_result;

    // Branch offsets are even, odd halfwords would break fetch
    assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("execute_stage: pc %h not word aligned", pc);

endmodule

`default_nettype wire

// ==== hdl/operand_fetch.sv ====
`default_nettype none

module operand_fetch (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire riscv_isa_pkg::instr_t instr,     // Current instruction
    input  wire                        wb_en,     // Write rd this cycle
    input  wire riscv_isa_pkg::word_t  wb_data,   // Value for rd
    output riscv_isa_pkg::word_t       rs1_data,
    output riscv_isa_pkg::word_t       rs2_data,
    output riscv_isa_pkg::word_t       imm        // Sign-extended immediate
);

    ////////////////////////////////////////
    // Field extraction
    ////////////////////////////////////////
    riscv_isa_pkg::opcode_t  opcode;
    riscv_isa_pkg::reg_idx_t rs1_idx;
    riscv_isa_pkg::reg_idx_t rs2_idx;
    riscv_isa_pkg::reg_idx_t rd_idx;

    assign opcode  = instr[6:0];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];
    assign rd_idx  = instr[11:7];

    ////////////////////////////////////////
    // Register file
    ////////////////////////////////////////
    // x0 is a real entry that reset clears and no write reaches
    riscv_isa_pkg::word_t regs [riscv_isa_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < riscv_isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (rd_idx != '0)) begin  // Writes to x0 dropped
            regs[rd_idx] <= wb_data;
        end
    end

    // Combinational read ports
    // New value visible the cycle after wb_en
    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

    ////////////////////////////////////////
    // Immediate generator
    ////////////////////////////////////////
    always_comb begin
        case (opcode)
            riscv_isa_pkg::OP_I_TYPE,
            riscv_isa_pkg::OP_LOAD: begin
                // I format imm[11:0] from instr[31:20]
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            riscv_isa_pkg::OP_STORE: begin
                // S format split around the rd field
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            riscv_isa_pkg::OP_BRANCH: begin
                // B format with bit 0 always zero
                imm = {{19{instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};
            end
            default: begin
                imm = '0;  // R-type and unknown
            end
        endcase
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    // x0 reads zero whatever was written to rd = 0 before
    assert property (@(posedge clk) disable iff (!rst_n)
        (rs1_idx == '0) |-> (rs1_data == '0))
        else $error("operand_fetch: x0 read on rs1 returned %h", rs1_data);

    assert property (@(posedge clk) disable iff (!rst_n)
        (rs2_idx == '0) |-> (rs2_data == '0))
        else $error("operand_fetch: x0 read on rs2 returned %h", rs2_data);

endmodule

`default_nettype wire

// ==== hdl/control_unit.sv ====
`default_nettype none

module control_unit (
    input  wire riscv_isa_pkg::opcode_t opcode,  // instr[6:0]
    output logic                        reg_write,  // Writeback to rd
    output logic                        mem_read,   // lw
    output logic                        mem_write,  // sw
    output logic                        branch,     // beq/bne
    output logic                        alu_src,    // 1 selects imm as ALU operand b
    output core_ctrl_pkg::alu_op_t      alu_op      // Instruction class
);

    ////////////////////////////////////////
    // Opcode decode
    ////////////////////////////////////////
    always_comb begin
        // Everything idle unless a known opcode shows up
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        alu_src   = 1'b0;
        alu_op    = core_ctrl_pkg::ALU_OP_ADDR;

        case (opcode)
            riscv_isa_pkg::OP_R_TYPE: begin
                reg_write = 1'b1;
                alu_op    = core_ctrl_pkg::ALU_OP_REG;  // funct fields pick op
            end
            riscv_isa_pkg::OP_I_TYPE: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;                        // rs1 op imm
                alu_op    = core_ctrl_pkg::ALU_OP_ADDR;
            end
            riscv_isa_pkg::OP_LOAD: begin
                reg_write = 1'b1;  // rd gets memory data
                mem_read  = 1'b1;
                alu_src   = 1'b1;  // Address is rs1 + imm
                alu_op    = core_ctrl_pkg::ALU_OP_ADDR;
            end
            riscv_isa_pkg::OP_STORE: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;  // Address is rs1 + imm
                alu_op    = core_ctrl_pkg::ALU_OP_ADDR;
            end
            riscv_isa_pkg::OP_BRANCH: begin
                branch    = 1'b1;
                alu_op    = core_ctrl_pkg::ALU_OP_BRANCH;  // rs1 - rs2
            end
            default: begin
                // Unknown opcode
                // No write, no strobe, pc just steps
            end
        endcase
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    // Memory port has one address, never read and write at once
    always_comb begin
        assert (!(mem_read && mem_write))
            else $error("control_unit: mem_read and mem_write both high, opcode %b",
                        opcode);
    end

endmodule

`default_nettype wire

// ==== hdl/core_ctrl_pkg.sv ====
`default_nettype none

package core_ctrl_pkg;

    ////////////////////////////////////////
    // Instruction class from the decoder
    ////////////////////////////////////////
    typedef logic [1:0] alu_op_t;

    localparam alu_op_t ALU_OP_ADDR   = 2'b00;  // Immediate ops and lw/sw address
    localparam alu_op_t ALU_OP_BRANCH = 2'b01;  // Compare for beq/bne
    localparam alu_op_t ALU_OP_REG    = 2'b10;  // R-type, funct3/funct7 decide

    ////////////////////////////////////////
    // ALU function inside the execute stage
    ////////////////////////////////////////
    typedef logic [2:0] alu_sel_t;

    localparam alu_sel_t ALU_ADD = 3'd0;
    localparam alu_sel_t ALU_SUB = 3'd1;  // Also the branch compare
    localparam alu_sel_t ALU_AND = 3'd2;
    localparam alu_sel_t ALU_OR  = 3'd3;
    localparam alu_sel_t ALU_SLT = 3'd4;  // Signed less-than, 0 or 1

    // Codes 5 to 7 unused, ALU returns zero for them

endpackage

`default_nettype wire

// ==== hdl/riscv_isa_pkg.sv ====
`default_nettype none

package riscv_isa_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int XLEN      = 32;  // Data path width
    localparam int NUM_REGS  = 32;  // x0 to x31
    localparam int REG_IDX_W = 5;   // log2 of NUM_REGS

    typedef logic [XLEN-1:0]      word_t;     // Register or memory word
    typedef logic [XLEN-1:0]      addr_t;     // Byte address
    typedef logic [31:0]          instr_t;    // Raw instruction
    typedef logic [6:0]           opcode_t;   // instr[6:0]
    typedef logic [REG_IDX_W-1:0] reg_idx_t;  // rs1, rs2 or rd

    ////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////
    localparam opcode_t OP_R_TYPE = 7'b0110011;  // add, sub, and, or, slt
    localparam opcode_t OP_I_TYPE = 7'b0010011;  // addi, andi, ori, slti
    localparam opcode_t OP_LOAD   = 7'b0000011;  // lw
    localparam opcode_t OP_STORE  = 7'b0100011;  // sw
    localparam opcode_t OP_BRANCH = 7'b1100011;  // beq, bne

    ////////////////////////////////////////
    // funct3 values
    ////////////////////////////////////////
    // Arithmetic group, shared by R and I formats
    localparam logic [2:0] F3_ADD_SUB = 3'b000;  // funct7[5] picks sub on R-type
    localparam logic [2:0] F3_SLT     = 3'b010;  // Signed compare
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch group
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    ////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////
    localparam addr_t RESET_PC    = 32'h0000_0000;  // First fetch after reset
    localparam addr_t INSTR_BYTES = 32'd4;          // Sequential pc step

endpackage

`default_nettype wire
